// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_mem_wb
FILELIST   := verilog.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: source/data_memory.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module data_memory
import mem_pkg::*;
#(
    parameter int READ_LATENCY = `MEM_READ_LATENCY
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              mem_read,
    input  logic              mem_write,
    input  access_size_t      access_size,
    input  logic [`XLEN-1:0]  addr,
    input  logic [`XLEN-1:0]  store_data,
    output logic [`XLEN-1:0]  read_data,
    output logic              mem_ready,
    output logic              mem_busy
);

    localparam int ADDR_W = $clog2(`MEM_DEPTH_WORDS);
    localparam int CNT_W  = $clog2(READ_LATENCY + 1);

    logic [`XLEN-1:0] mem [`MEM_DEPTH_WORDS];
    logic [ADDR_W-1:0] word_idx;
    logic [1:0] offset;
    mem_word_u store_word;
    logic [`XLEN-1:0] rd_word;
    logic [CNT_W-1:0] cnt;

    assign word_idx = addr[ADDR_W+1:2];
    assign offset   = addr[1:0];

    // merge store data into the addressed lanes
    always_comb begin
        store_word.word = mem[word_idx];
        case (access_size)
            size_byte: store_word.bytes[offset] = store_data[7:0];
            size_half: store_word.halves[offset[1]] = store_data[15:0];
            default:   store_word.word = store_data;
        endcase
    end

    // stores land at the request edge
    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[word_idx] <= store_word.word;
        end
    end

    // word is sampled at request time and held until ready
    always_ff @(posedge clk) begin
        if (mem_read && !mem_busy) begin
            rd_word <= mem[word_idx];
        end
    end

    assign read_data = rd_word;

    // busy / ready sequencing
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            mem_busy  <= 1'b0;
            mem_ready <= 1'b0;
            cnt       <= '0;
        end else if (mem_ready) begin
            // ready cycle ends the access
            mem_ready <= 1'b0;
            mem_busy  <= 1'b0;
        end else if (mem_busy) begin
            cnt <= cnt - 1'b1;
            if (cnt == CNT_W'(1)) begin
                mem_ready <= 1'b1;
            end
        end else if (mem_read) begin
            mem_busy <= 1'b1;
            cnt      <= CNT_W'(READ_LATENCY);
        end
    end

    // upstream must hold off reads while busy
    assert property (@(posedge clk) disable iff (!rstN) mem_busy |-> !mem_read);

    // no stores during a pending load
    assert property (@(posedge clk) disable iff (!rstN) mem_busy |-> !mem_write);

endmodule

`default_nettype wire

// File: source/load_align.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module load_align
import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              mem_read,
    input  access_size_t      access_size,
    input  logic              load_unsigned,
    input  logic [1:0]        addr_offset,
    input  logic [`XLEN-1:0]  read_data,
    output logic [`XLEN-1:0]  load_data
);

    access_size_t size_q;
    logic [1:0] offset_q;
    logic unsigned_q;
    mem_word_u rd_word;
    logic [7:0] byte_lane;
    logic [15:0] half_lane;

    // attributes of the load in flight
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            size_q     <= size_word;
            offset_q   <= 2'b00;
            unsigned_q <= 1'b0;
        end else if (mem_read) begin
            size_q     <= access_size;
            offset_q   <= addr_offset;
            unsigned_q <= load_unsigned;
        end
    end

    assign rd_word.word = read_data;
    assign byte_lane    = rd_word.bytes[offset_q];
    assign half_lane    = rd_word.halves[offset_q[1]];

    // lane select, then sign or zero extend
    always_comb begin
        case (size_q)
            size_byte: load_data = {{(`XLEN-8){byte_lane[7] & ~unsigned_q}}, byte_lane};
            size_half: load_data = {{(`XLEN-16){half_lane[15] & ~unsigned_q}}, half_lane};
            default:   load_data = rd_word.word;
        endcase
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (mem_read && access_size == size_half) |-> !addr_offset[0]);

endmodule

`default_nettype wire

// File: source/mem_pkg.sv
`default_nettype none

`include "riscv_macros.svh"

package mem_pkg;

    // load and store access width
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } access_size_t;

    // one memory word, seen whole or by lanes
    // bytes[0] and halves[0] sit in the low bits
    typedef union packed {
        logic [`XLEN-1:0]                  word;
        logic [`XLEN_BYTES-1:0][7:0]       bytes;
        logic [`XLEN_HALVES-1:0][15:0]     halves;
    } mem_word_u;

endpackage

`default_nettype wire

// File: source/mem_wb_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module mem_wb_top
import pipeline_pkg::*;
import mem_pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    // from the execute-stage driver
    input  logic              reg_write,
    input  logic              mem_to_reg,
    input  logic              mem_read,
    input  logic              mem_write,
    input  access_size_t      access_size,
    input  logic              load_unsigned,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  store_data,
    input  regName_t          rd,
    output logic              mem_busy,
    // observer side
    input  regName_t          rs_addr,
    output logic [`XLEN-1:0]  rs_data,
    output logic              wb_en,
    output regName_t          wb_rd,
    output logic [`XLEN-1:0]  wb_data
);

    logic [`XLEN-1:0] read_data;
    logic [`XLEN-1:0] load_data;
    logic mem_ready;
    wb_src_t mem_wb_src;
    logic wb_reg_write;
    wb_src_t wb_src;
    logic [`XLEN-1:0] wb_load_data;
    logic [`XLEN-1:0] wb_alu_result;

    assign mem_wb_src = mem_to_reg ? wb_load : wb_alu;

    data_memory i_data_memory (
        .clk        (clk),
        .rstN       (rstN),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .access_size(access_size),
        .addr       (alu_result),
        .store_data (store_data),
        .read_data  (read_data),
        .mem_ready  (mem_ready),
        .mem_busy   (mem_busy)
    );

    load_align i_load_align (
        .clk          (clk),
        .rstN         (rstN),
        .mem_read     (mem_read),
        .access_size  (access_size),
        .load_unsigned(load_unsigned),
        .addr_offset  (alu_result[1:0]),
        .read_data    (read_data),
        .load_data    (load_data)
    );

    pipeline_register_mem_wb i_pipeline_register_mem_wb (
        .clk           (clk),
        .rstN          (rstN),
        .reg_write_in  (reg_write),
        .wb_src_in     (mem_wb_src),
        .load_data_in  (load_data),
        .alu_result_in (alu_result),
        .rd_in         (rd),
        .mem_read_in   (mem_read),
        .mem_ready_in  (mem_ready),
        .reg_write_out (wb_reg_write),
        .wb_src_out    (wb_src),
        .load_data_out (wb_load_data),
        .alu_result_out(wb_alu_result),
        .rd_out        (wb_rd)
    );

    writeback_regfile i_writeback_regfile (
        .clk       (clk),
        .rstN      (rstN),
        .reg_write (wb_reg_write),
        .wb_src    (wb_src),
        .load_data (wb_load_data),
        .alu_result(wb_alu_result),
        .rd        (wb_rd),
        .rs_addr   (rs_addr),
        .rs_data   (rs_data),
        .wb_en     (wb_en),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

// File: source/pipeline_pkg.sv
`default_nettype none

package pipeline_pkg;

    // architectural register names, abi order
    // zero doubles as "no destination"
    typedef enum logic [4:0] {
        zero, ra, sp, gp,
        tp, t0, t1, t2,
        s0, s1,
        a0, a1, a2, a3,
        a4, a5, a6, a7,
        s2, s3, s4, s5,
        s6, s7, s8, s9,
        s10, s11,
        t3, t4, t5, t6
    } regName_t;

    // writeback source select
    typedef enum logic {
        wb_alu  = 1'b0,
        wb_load = 1'b1
    } wb_src_t;

endpackage

`default_nettype wire

// File: source/pipeline_register_mem_wb.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module pipeline_register_mem_wb
import pipeline_pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    // control from the memory stage
    input  logic              reg_write_in,
    input  wb_src_t           wb_src_in,
    // data from the memory stage
    input  logic [`XLEN-1:0]  load_data_in,
    input  logic [`XLEN-1:0]  alu_result_in,
    input  regName_t          rd_in,
    // load handshake levels
    input  logic              mem_read_in,
    input  logic              mem_ready_in,
    // to writeback
    output logic              reg_write_out,
    output wb_src_t           wb_src_out,
    output logic [`XLEN-1:0]  load_data_out,
    output logic [`XLEN-1:0]  alu_result_out,
    output regName_t          rd_out
);

    typedef enum logic {
        st_idle,
        st_reading
    } load_state_t;

    load_state_t state, state_next;
    regName_t rd_next, hold_rd, hold_rd_next;
    logic reg_write_next, hold_reg_write, hold_reg_write_next;
    wb_src_t wb_src_next;

    // control path, with the held load substituted on ready
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state          <= st_idle;
            hold_rd        <= zero;
            hold_reg_write <= 1'b0;
            rd_out         <= zero;
            reg_write_out  <= 1'b0;
            wb_src_out     <= wb_alu;
        end else begin
            state          <= state_next;
            hold_rd        <= hold_rd_next;
            hold_reg_write <= hold_reg_write_next;
            rd_out         <= rd_next;
            reg_write_out  <= reg_write_next;
            wb_src_out     <= wb_src_next;
        end
    end

    always_ff @(posedge clk) begin
        load_data_out  <= load_data_in;
        alu_result_out <= alu_result_in;
    end

    always_comb begin
        state_next          = state;
        rd_next             = rd_in;
        reg_write_next      = reg_write_in;
        wb_src_next         = wb_src_in;
        hold_rd_next        = hold_rd;
        hold_reg_write_next = hold_reg_write;

        case (state)
            st_idle: begin
                if (mem_read_in) begin
                    // park the destination until the data shows up
                    rd_next             = zero;
                    hold_rd_next        = rd_in;
                    hold_reg_write_next = reg_write_in;
                    state_next          = st_reading;
                end
            end
            st_reading: begin
                if (mem_ready_in) begin
                    rd_next        = hold_rd;
                    reg_write_next = hold_reg_write;
                    wb_src_next    = wb_load;
                    state_next     = st_idle;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    // memory only answers a load this register is waiting on
    assert property (@(posedge clk) disable iff (!rstN) (state == st_idle) |-> !mem_ready_in);

endmodule

`default_nettype wire

// File: source/riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// data and address word width
`define XLEN 32

// data memory size in 32-bit words
`define MEM_DEPTH_WORDS 256

// cycles from a read request edge to mem_ready
`define MEM_READ_LATENCY 3

// byte lanes per word
`define XLEN_BYTES (`XLEN / 8)

// halfword lanes per word
`define XLEN_HALVES (`XLEN / 16)

`endif

// File: source/writeback_regfile.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module writeback_regfile
import pipeline_pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    // from the MEM/WB register
    input  logic              reg_write,
    input  wb_src_t           wb_src,
    input  logic [`XLEN-1:0]  load_data,
    input  logic [`XLEN-1:0]  alu_result,
    input  regName_t          rd,
    // observation read port
    input  regName_t          rs_addr,
    output logic [`XLEN-1:0]  rs_data,
    // visible writeback
    output logic              wb_en,
    output logic [`XLEN-1:0]  wb_data
);

    logic [`XLEN-1:0] regs [32];

    // result select
    always_comb begin
        case (wb_src)
            wb_load: wb_data = load_data;
            default: wb_data = alu_result;
        endcase
    end

    // writes to zero are dropped
    assign wb_en = reg_write && (rd != zero);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[rd] <= wb_data;
        end
    end

    // zero is hardwired
    always_comb begin
        if (rs_addr == zero) begin
            rs_data = '0;
        end else begin
            rs_data = regs[rs_addr];
        end
    end

endmodule

`default_nettype wire

// File: test/tb_mem_wb.sv
`default_nettype none
`timescale 1ns/10ps

`include "riscv_macros.svh"

module tb_mem_wb
import pipeline_pkg::*;
import mem_pkg::*;
;

    localparam int CLK_PERIOD     = 10;
    localparam int BUSY_LIMIT     = `MEM_READ_LATENCY + 4;
    localparam int NUM_ALU_WRITES = 16;
    localparam int NUM_WORD_LOADS = 4;
    // word loads, 8 byte loads, 4 half loads, 1 merged word load, 1 load to x0
    localparam int NUM_LOADS      = NUM_WORD_LOADS + 14;
    localparam int NUM_STORES     = NUM_WORD_LOADS + 8;
    localparam int LOAD_CYCLES    = `MEM_READ_LATENCY + 6;
    localparam int TEST_CYCLES    = 4 * 32 + (NUM_ALU_WRITES + 2) * 4
                                  + NUM_LOADS * LOAD_CYCLES + NUM_STORES * 2 + 16;
    localparam int WATCHDOG_NS    = 2 * TEST_CYCLES * CLK_PERIOD;

    logic clk;
    logic rstN;
    logic reg_write;
    logic mem_to_reg;
    logic mem_read;
    logic mem_write;
    access_size_t access_size;
    logic load_unsigned;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] store_data;
    regName_t rd;
    logic mem_busy;
    regName_t rs_addr;
    logic [`XLEN-1:0] rs_data;
    logic wb_en;
    regName_t wb_rd;
    logic [`XLEN-1:0] wb_data;

    // reference model
    logic [`XLEN-1:0] reg_model [32];
    logic [`XLEN-1:0] mem_model [`MEM_DEPTH_WORDS];
    int checks;
    int errors;

    mem_wb_top i_mem_wb_top (
        .clk          (clk),
        .rstN         (rstN),
        .reg_write    (reg_write),
        .mem_to_reg   (mem_to_reg),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .access_size  (access_size),
        .load_unsigned(load_unsigned),
        .alu_result   (alu_result),
        .store_data   (store_data),
        .rd           (rd),
        .mem_busy     (mem_busy),
        .rs_addr      (rs_addr),
        .rs_data      (rs_data),
        .wb_en        (wb_en),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // little-endian store lane merge
    function automatic logic [31:0] merge_store(logic [31:0] old_word, access_size_t size,
                                                logic [1:0] offset, logic [31:0] data);
        logic [31:0] mask;
        logic [31:0] lanes;
        case (size)
            size_byte: begin
                mask  = 32'h0000_00ff << {offset, 3'b000};
                lanes = (data & 32'h0000_00ff) << {offset, 3'b000};
            end
            size_half: begin
                mask  = 32'h0000_ffff << {offset[1], 4'b0000};
                lanes = (data & 32'h0000_ffff) << {offset[1], 4'b0000};
            end
            default: begin
                mask  = 32'hffff_ffff;
                lanes = data;
            end
        endcase
        return (old_word & ~mask) | lanes;
    endfunction

    // lane pick then sign or zero extension
    function automatic logic [31:0] extract_load(logic [31:0] word, access_size_t size,
                                                 logic [1:0] offset, logic is_unsigned);
        logic [31:0] lane;
        case (size)
            size_byte: begin
                lane = (word >> {offset, 3'b000}) & 32'h0000_00ff;
                if (!is_unsigned && lane[7]) lane = lane | 32'hffff_ff00;
            end
            size_half: begin
                lane = (word >> {offset[1], 4'b0000}) & 32'h0000_ffff;
                if (!is_unsigned && lane[15]) lane = lane | 32'hffff_0000;
            end
            default: lane = word;
        endcase
        return lane;
    endfunction

    function automatic regName_t pick_reg();
        logic [4:0] idx;
        idx = 5'($urandom_range(31, 1));
        return regName_t'(idx);
    endfunction

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic check_bit(string name, logic got, logic expected);
        checks++;
        assert (got === expected) else begin
            errors++;
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    // one edge, then the drive point
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_bubble();
        reg_write     = 1'b0;
        mem_to_reg    = 1'b0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        access_size   = size_word;
        load_unsigned = 1'b0;
        alu_result    = '0;
        store_data    = '0;
        rd            = zero;
    endtask

    task automatic wait_not_busy();
        int cycles;
        cycles = 0;
        while (mem_busy && cycles < BUSY_LIMIT) begin
            step();
            cycles++;
        end
        assert (!mem_busy) else begin
            errors++;
            $display("memory still busy after %0d cycles at %0t", cycles, $time);
        end
    endtask

    task automatic check_reg(regName_t r);
        rs_addr = r;
        step();
        check_value($sformatf("rs_data[%s]", r.name()), rs_data, reg_model[r]);
    endtask

    task automatic check_all_regs();
        for (int r = 0; r < 32; r++) begin
            check_reg(regName_t'(r[4:0]));
        end
    endtask

    // alu instruction written two edges later
    task automatic issue_alu(regName_t dest, logic [31:0] value);
        reg_write  = 1'b1;
        alu_result = value;
        rd         = dest;
        step();
        drive_bubble();
        // writes to x0 never reach the register file
        check_bit("wb_en", wb_en, dest != zero);
        check_value("wb_rd", {27'd0, wb_rd}, {27'd0, dest});
        check_value("wb_data", wb_data, value);
        step();
        if (dest != zero) reg_model[dest] = value;
    endtask

    task automatic alu_write(regName_t dest, logic [31:0] value);
        wait_not_busy();
        issue_alu(dest, value);
        check_reg(dest);
    endtask

    task automatic store(logic [31:0] addr, access_size_t size, logic [31:0] data);
        wait_not_busy();
        mem_write   = 1'b1;
        access_size = size;
        alu_result  = addr;
        store_data  = data;
        step();
        drive_bubble();
        check_bit("mem_busy", mem_busy, 1'b0);
        mem_model[addr[9:2]] = merge_store(mem_model[addr[9:2]], size, addr[1:0], data);
    endtask

    // returns at the drive point right after mem_busy falls
    task automatic start_load(regName_t dest, logic [31:0] addr, access_size_t size,
                              logic is_unsigned, output logic [31:0] expected);
        int cycles;
        logic [31:0] old_val;
        wait_not_busy();
        old_val  = reg_model[dest];
        expected = extract_load(mem_model[addr[9:2]], size, addr[1:0], is_unsigned);
        reg_write     = 1'b1;
        mem_to_reg    = 1'b1;
        mem_read      = 1'b1;
        access_size   = size;
        load_unsigned = is_unsigned;
        alu_result    = addr;
        rd            = dest;
        rs_addr       = dest;
        step();
        drive_bubble();
        check_bit("mem_busy", mem_busy, 1'b1);
        cycles = 0;
        while (mem_busy && cycles < BUSY_LIMIT) begin
            check_value("rs_data", rs_data, old_val);
            check_bit("wb_en", wb_en, 1'b0);
            step();
            cycles++;
        end
        assert (!mem_busy) else begin
            errors++;
            $display("load at %h never completed, mem_busy stuck high at %0t", addr, $time);
        end
        // held destination goes out with the data
        // register write follows one edge later
        check_value("rs_data", rs_data, old_val);
        check_bit("wb_en", wb_en, dest != zero);
        check_value("wb_rd", {27'd0, wb_rd}, {27'd0, dest});
        if (dest != zero) check_value("wb_data", wb_data, expected);
    endtask

    task automatic load(regName_t dest, logic [31:0] addr, access_size_t size,
                        logic is_unsigned);
        logic [31:0] expected;
        start_load(dest, addr, size, is_unsigned, expected);
        step();
        if (dest != zero) reg_model[dest] = expected;
        check_value($sformatf("rs_data[%s]", dest.name()), rs_data, reg_model[dest]);
    endtask

    function automatic logic [31:0] pick_word_addr();
        logic [7:0] idx;
        idx = 8'($urandom_range(`MEM_DEPTH_WORDS - 1, 0));
        return {22'd0, idx, 2'b00};
    endfunction

    task automatic test_reset_state();
        check_bit("mem_busy", mem_busy, 1'b0);
        check_bit("wb_en", wb_en, 1'b0);
        check_all_regs();
    endtask

    task automatic test_alu_writes();
        for (int n = 0; n < NUM_ALU_WRITES; n++) begin
            alu_write(pick_reg(), $urandom);
        end
        alu_write(zero, 32'hdead_beef);
        check_all_regs();
    endtask

    task automatic test_word_store_load();
        logic [31:0] addr;
        for (int n = 0; n < NUM_WORD_LOADS; n++) begin
            addr = pick_word_addr();
            store(addr, size_word, $urandom);
            load(pick_reg(), addr, size_word, 1'b0);
        end
    endtask

    task automatic test_partial_access();
        logic [31:0] base;
        logic [31:0] data;
        base = pick_word_addr();
        store(base, size_word, $urandom);
        // top bit alternates so both extensions are hit
        for (int off = 0; off < 4; off++) begin
            data    = $urandom;
            data[7] = off[0];
            store(base + 32'(off), size_byte, data);
            load(pick_reg(), base + 32'(off), size_byte, 1'b0);
            load(pick_reg(), base + 32'(off), size_byte, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            data     = $urandom;
            data[15] = off[1];
            store(base + 32'(off), size_half, data);
            load(pick_reg(), base + 32'(off), size_half, 1'b0);
            load(pick_reg(), base + 32'(off), size_half, 1'b1);
        end
        load(pick_reg(), base, size_word, 1'b0);
    endtask

    task automatic test_zero_load_then_alu();
        logic [31:0] addr;
        logic [31:0] expected;
        regName_t dest;
        addr = pick_word_addr();
        dest = pick_reg();
        store(addr, size_word, $urandom);
        start_load(zero, addr, size_word, 1'b0, expected);
        // alu op right behind the load to x0
        issue_alu(dest, $urandom);
        check_reg(dest);
        check_reg(zero);
    endtask

    initial begin
        void'($urandom(32'h1ad2));
        checks     = 0;
        errors     = 0;
        clk        = 1'b0;
        rstN       = 1'b0;
        rs_addr    = zero;
        drive_bubble();
        for (int r = 0; r < 32; r++) reg_model[r] = '0;
        for (int w = 0; w < `MEM_DEPTH_WORDS; w++) mem_model[w] = '0;
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;

        test_reset_state();
        test_alu_writes();
        test_word_store_load();
        test_partial_access();
        test_zero_load_then_alu();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+source
source/pipeline_pkg.sv
source/mem_pkg.sv
source/data_memory.sv
source/load_align.sv
source/pipeline_register_mem_wb.sv
source/writeback_regfile.sv
source/mem_wb_top.sv
test/tb_mem_wb.sv
